// File: Bender.yml
package:
  name: cache_bank

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cache_pkg.sv
      - hdl/credit_fifo.sv
      - hdl/tag_data_store.sv
      - hdl/bank_controller.sv
      - hdl/cache_bank.sv
  - target: test
    include_dirs:
      - hdl
      - test
    files:
      - test/cache_bank_tb.sv

// File: build.f
+incdir+hdl
+incdir+test
hdl/cache_pkg.sv
hdl/credit_fifo.sv
hdl/tag_data_store.sv
hdl/bank_controller.sv
hdl/cache_bank.sv
test/cache_bank_tb.sv

// File: hdl/bank_controller.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module bank_controller
    import cache_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          req_valid,
    input  core_req_t                     req_data,
    output logic                          req_done,

    output logic                          core_rsp_valid,
    output logic [31:0]                   core_rsp_data,

    output cache_index_t                  read_index,
    input  logic                          read_valid,
    input  logic                          read_dirty,
    input  cache_tag_t                    read_tag,
    input  line_data_t                    read_data,

    output cache_index_t                  write_index,
    output cache_tag_t                    write_tag,
    output logic [`CACHE_LINE_BYTES-1:0]  write_byte_en,
    output line_data_t                    write_data,
    output logic                          write_fill,
    output logic                          invalidate,
    output logic                          fill_sent,

    output logic                          dram_push,
    output dram_req_t                     dram_push_data,
    input  logic                          dram_queue_credit,

    input  logic                          dram_rsp_valid,
    input  line_data_t                    dram_rsp_data
);

    localparam int FREE_W = $clog2(`DRAM_REQQ_DEPTH + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITEBACK,
        S_FILL_REQ,
        S_FILL_WAIT,
        S_INSTALL,
        S_RESPOND
    } state_t;

    state_t                            state_q;
    state_t                            state_d;
    logic [FREE_W-1:0]                 dram_free_q;
    core_req_t                         req_q;
    line_data_t                        fill_q;
    logic [31:0]                       rsp_q;

    cache_index_t                      req_index;
    cache_tag_t                        req_tag;
    logic [`CACHE_OFFSET_BITS-3:0]     word_sel;
    logic                              hit;
    logic [31:0]                       old_word;
    logic [31:0]                       merged_word;

    // Split the held request address
    assign req_index = req_q.addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
    assign req_tag   = req_q.addr[31 -: `CACHE_TAG_BITS];
    assign word_sel  = req_q.addr[`CACHE_OFFSET_BITS-1:2];

    assign read_index = req_index;
    assign hit        = read_valid && (read_tag == req_tag);
    assign old_word   = read_data[word_sel];

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged_word[b * 8 +: 8] = req_q.byte_en[b] ? req_q.wdata[b * 8 +: 8]
                                                       : old_word[b * 8 +: 8];
        end
    end

    assign core_rsp_valid = (state_q == S_RESPOND);
    assign core_rsp_data  = rsp_q;
    assign req_done       = (state_q == S_RESPOND);

    always_comb begin
        state_d             = state_q;
        write_index         = req_index;
        write_tag           = req_tag;
        write_byte_en       = '0;
        write_data          = {`CACHE_LINE_WORDS{merged_word}};
        write_fill          = 1'b0;
        invalidate          = 1'b0;
        fill_sent           = 1'b0;
        dram_push           = 1'b0;
        dram_push_data.write = 1'b0;
        dram_push_data.addr  = {req_tag, req_index, {`CACHE_OFFSET_BITS{1'b0}}};
        dram_push_data.data  = '0;

        case (state_q)
            S_IDLE: begin
                if (req_valid) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (req_q.op == OP_FLUSH) begin
                    if (hit && read_dirty) begin
                        state_d = S_WRITEBACK;
                    end else begin
                        // Clean hit is simply dropped, a miss is a no-op
                        invalidate = hit;
                        state_d    = S_RESPOND;
                    end
                end else if (hit) begin
                    if (req_q.op == OP_WRITE) begin
                        write_byte_en[word_sel * 4 +: 4] = req_q.byte_en;
                    end
                    state_d = S_RESPOND;
                end else if (read_valid && read_dirty) begin
                    state_d = S_WRITEBACK;
                end else begin
                    state_d = S_FILL_REQ;
                end
            end
            S_WRITEBACK: begin
                // Victim address comes from the stored tag
                dram_push_data.write = 1'b1;
                dram_push_data.addr  = {read_tag, req_index, {`CACHE_OFFSET_BITS{1'b0}}};
                dram_push_data.data  = read_data;
                if (dram_free_q != '0) begin
                    dram_push = 1'b1;
                    fill_sent = 1'b1;
                    if (req_q.op == OP_FLUSH) begin
                        invalidate = 1'b1;
                        state_d    = S_RESPOND;
                    end else begin
                        state_d = S_FILL_REQ;
                    end
                end
            end
            S_FILL_REQ: begin
                if (dram_free_q != '0) begin
                    dram_push = 1'b1;
                    state_d   = S_FILL_WAIT;
                end
            end
            S_FILL_WAIT: begin
                if (dram_rsp_valid) begin
                    state_d = S_INSTALL;
                end
            end
            S_INSTALL: begin
                write_byte_en = '1;
                write_data    = fill_q;
                write_fill    = 1'b1;
                // Replay now hits
                state_d       = S_LOOKUP;
            end
            S_RESPOND: begin
                state_d = S_IDLE;
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= S_IDLE;
            dram_free_q <= FREE_W'(`DRAM_REQQ_DEPTH);
        end else begin
            state_q     <= state_d;
            dram_free_q <= dram_free_q + FREE_W'(dram_queue_credit) - FREE_W'(dram_push);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req_valid) begin
            req_q <= req_data;
        end
        if (state_q == S_FILL_WAIT && dram_rsp_valid) begin
            fill_q <= dram_rsp_data;
        end
        // On a miss this gets overwritten during the replay lookup
        if (state_q == S_LOOKUP) begin
            case (req_q.op)
                OP_WRITE: rsp_q <= merged_word;
                OP_READ:  rsp_q <= old_word;
                default:  rsp_q <= '0;
            endcase
        end
    end

endmodule

// File: hdl/cache_bank.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_bank
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  logic         core_req_valid,
    input  cache_op_t    core_req_op,
    input  logic [31:0]  core_req_addr,
    input  logic [31:0]  core_req_wdata,
    input  logic [3:0]   core_req_byte_en,
    output logic         core_req_credit,
    output logic         core_rsp_valid,
    output logic [31:0]  core_rsp_data,

    output logic         dram_req_valid,
    output logic         dram_req_write,
    output logic [31:0]  dram_req_addr,
    output line_data_t   dram_req_data,
    input  logic         dram_req_credit,
    input  logic         dram_rsp_valid,
    input  line_data_t   dram_rsp_data
);

    core_req_t                     core_req_in;
    core_req_t                     ctrl_req;
    logic                          ctrl_req_valid;
    logic                          ctrl_req_done;

    cache_index_t                  read_index;
    logic                          read_valid;
    logic                          read_dirty;
    cache_tag_t                    read_tag;
    line_data_t                    read_data;
    cache_index_t                  write_index;
    cache_tag_t                    write_tag;
    logic [`CACHE_LINE_BYTES-1:0]  write_byte_en;
    line_data_t                    write_data;
    logic                          write_fill;
    logic                          invalidate;
    logic                          fill_sent;

    logic                          dram_push;
    dram_req_t                     dram_push_data;
    logic                          dram_queue_credit;
    dram_req_t                     dram_req_out;

    // Pack the core request fields for the queue
    assign core_req_in.op      = core_req_op;
    assign core_req_in.addr    = core_req_addr;
    assign core_req_in.wdata   = core_req_wdata;
    assign core_req_in.byte_en = core_req_byte_en;

    // Controller takes one request at a time
    credit_fifo #(
        .payload_t    (core_req_t),
        .DEPTH        (`CORE_REQQ_DEPTH),
        .SINK_CREDITS (1)
    ) core_req_queue (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (core_req_valid),
        .in_data    (core_req_in),
        .in_credit  (core_req_credit),
        .out_valid  (ctrl_req_valid),
        .out_data   (ctrl_req),
        .out_credit (ctrl_req_done)
    );

    bank_controller bank_controller_i (
        .clk               (clk),
        .reset             (reset),
        .req_valid         (ctrl_req_valid),
        .req_data          (ctrl_req),
        .req_done          (ctrl_req_done),
        .core_rsp_valid    (core_rsp_valid),
        .core_rsp_data     (core_rsp_data),
        .read_index        (read_index),
        .read_valid        (read_valid),
        .read_dirty        (read_dirty),
        .read_tag          (read_tag),
        .read_data         (read_data),
        .write_index       (write_index),
        .write_tag         (write_tag),
        .write_byte_en     (write_byte_en),
        .write_data        (write_data),
        .write_fill        (write_fill),
        .invalidate        (invalidate),
        .fill_sent         (fill_sent),
        .dram_push         (dram_push),
        .dram_push_data    (dram_push_data),
        .dram_queue_credit (dram_queue_credit),
        .dram_rsp_valid    (dram_rsp_valid),
        .dram_rsp_data     (dram_rsp_data)
    );

    tag_data_store tag_data_store_i (
        .clk           (clk),
        .reset         (reset),
        .read_index    (read_index),
        .read_valid    (read_valid),
        .read_dirty    (read_dirty),
        .read_tag      (read_tag),
        .read_data     (read_data),
        .write_index   (write_index),
        .write_tag     (write_tag),
        .write_byte_en (write_byte_en),
        .write_data    (write_data),
        .write_fill    (write_fill),
        .invalidate    (invalidate),
        .fill_sent     (fill_sent)
    );

    credit_fifo #(
        .payload_t    (dram_req_t),
        .DEPTH        (`DRAM_REQQ_DEPTH),
        .SINK_CREDITS (`DRAM_REQ_CREDITS)
    ) dram_req_queue (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (dram_push),
        .in_data    (dram_push_data),
        .in_credit  (dram_queue_credit),
        .out_valid  (dram_req_valid),
        .out_data   (dram_req_out),
        .out_credit (dram_req_credit)
    );

    assign dram_req_write = dram_req_out.write;
    assign dram_req_addr  = dram_req_out.addr;
    assign dram_req_data  = dram_req_out.data;

endmodule

// File: hdl/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

    // Core request kind
    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_FLUSH = 2'd2
    } cache_op_t;

    typedef logic [`CACHE_TAG_BITS-1:0]   cache_tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0] cache_index_t;

    // One full line, word 0 in the low bits
    typedef logic [`CACHE_LINE_WORDS-1:0][31:0] line_data_t;

    // Request as it sits in the core queue
    typedef struct packed {
        cache_op_t   op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byte_en;
    } core_req_t;

    // Writeback or fill request towards DRAM, address is line aligned
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        line_data_t  data;
    } dram_req_t;

endpackage

// File: hdl/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Line geometry
`define CACHE_LINE_WORDS    4
`define CACHE_LINE_BYTES    (`CACHE_LINE_WORDS * 4)
`define CACHE_LINE_COUNT    16

// Byte address split is tag | index | offset
`define CACHE_OFFSET_BITS   4
`define CACHE_INDEX_BITS    4
`define CACHE_TAG_BITS      (32 - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)

// Core side request queue, also the credits the core starts with
`define CORE_REQQ_DEPTH     4

// DRAM side request queue and the requests the DRAM can hold
`define DRAM_REQQ_DEPTH     2
`define DRAM_REQ_CREDITS    2

`endif

// File: hdl/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t    = logic,
    parameter int  DEPTH        = 2,
    parameter int  SINK_CREDITS = 1
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_credit,

    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_credit
);

    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(SINK_CREDITS + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;

    // Head goes out as soon as the sink has room for it
    assign out_valid = (count != '0) && (credits != '0);
    assign out_data  = mem[rd_ptr];

    // Every item sent frees one entry, so one credit goes back upstream
    assign in_credit = out_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count   <= '0;
            credits <= CRED_W'(SINK_CREDITS);
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (out_valid) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count   <= count + CNT_W'(in_valid) - CNT_W'(out_valid);
            credits <= credits + CRED_W'(out_credit) - CRED_W'(out_valid);
        end
    end

    // Upstream only pushes while it holds a credit, so there is always room
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

// File: hdl/tag_data_store.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module tag_data_store
    import cache_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,

    input  cache_index_t                  read_index,
    output logic                          read_valid,
    output logic                          read_dirty,
    output cache_tag_t                    read_tag,
    output line_data_t                    read_data,

    input  cache_index_t                  write_index,
    input  cache_tag_t                    write_tag,
    input  logic [`CACHE_LINE_BYTES-1:0]  write_byte_en,
    input  line_data_t                    write_data,
    input  logic                          write_fill,
    input  logic                          invalidate,
    input  logic                          fill_sent
);

    localparam int LINE_BYTES = `CACHE_LINE_BYTES;

    logic [`CACHE_LINE_COUNT-1:0] valid_q;
    logic [`CACHE_LINE_COUNT-1:0] dirty_q;
    cache_tag_t                   tag_q  [`CACHE_LINE_COUNT];
    line_data_t                   data_q [`CACHE_LINE_COUNT];
    logic                         any_write;

    assign any_write = |write_byte_en;

    // Lookup is combinational
    assign read_valid = valid_q[read_index];
    assign read_dirty = dirty_q[read_index];
    assign read_tag   = tag_q[read_index];
    assign read_data  = data_q[read_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (any_write) begin
                valid_q[write_index] <= 1'b1;
                // Fill data matches DRAM, core stores do not
                dirty_q[write_index] <= !write_fill;
            end else if (fill_sent) begin
                dirty_q[write_index] <= 1'b0;
            end

            // Invalidate wins over a write in the same cycle
            if (invalidate) begin
                valid_q[write_index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (any_write) begin
            tag_q[write_index] <= write_tag;
        end
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (write_byte_en[b]) begin
                data_q[write_index][b / 4][(b % 4) * 8 +: 8] <=
                    write_data[b / 4][(b % 4) * 8 +: 8];
            end
        end
    end

endmodule

// File: test/cache_bank_tests.svh
`ifndef CACHE_BANK_TESTS_SVH
`define CACHE_BANK_TESTS_SVH

task automatic check_reset_quiet();
    repeat (20) begin
        @(negedge clk);
        assert (!core_rsp_valid && !dram_req_valid && !core_req_credit)
            else report_mismatch("output activity right after reset");
    end
    next_cycle();
endtask

task automatic check_read_miss_hit();
    logic [31:0] addr;
    addr = 32'h0000_1234;
    dram_log.delete();
    issue(OP_READ, addr, '0, '0);
    wait_idle();
    assert (dram_log.size() == 1)
        else report_mismatch($sformatf("%0d DRAM requests for one miss", dram_log.size()));
    assert (!dram_log[0].write && dram_log[0].addr == line_base(addr))
        else report_mismatch($sformatf("fill at %h, expected a read of %h",
                                       dram_log[0].addr, line_base(addr)));
    // Same line again, should hit
    issue(OP_READ, addr + 32'h8, '0, '0);
    wait_idle();
    assert (dram_log.size() == 1) else report_mismatch("a read hit went to DRAM");
    assert (rsp_cycle - req_cycle == 3)
        else report_mismatch($sformatf("hit took %0d cycles, expected 3",
                                       rsp_cycle - req_cycle));
endtask

task automatic check_byte_writes();
    logic [31:0] addr;
    addr = 32'h0000_2248;
    issue(OP_WRITE, addr, 32'h1122_3344, 4'b0001);
    issue(OP_WRITE, addr, 32'haabb_ccdd, 4'b1100);
    issue(OP_READ, addr, '0, '0);
    wait_idle();
    // Pattern word c0de_0892 with byte 0 from the first write and bytes 3 and 2 from the second
    assert (last_rsp == 32'haabb_0844)
        else report_mismatch($sformatf("read back %h, expected aabb0844", last_rsp));
endtask

task automatic check_eviction();
    logic [31:0] old_addr;
    logic [31:0] new_addr;
    line_data_t  old_line;
    old_addr = 32'h0000_2248;
    new_addr = 32'h0005_2248;
    for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
        old_line[w] = ref_word(line_base(old_addr) + 32'(4 * w));
    end
    dram_log.delete();
    issue(OP_READ, new_addr, '0, '0);
    wait_idle();
    assert (dram_log.size() == 2)
        else report_mismatch($sformatf("%0d DRAM requests for an eviction", dram_log.size()));
    assert (dram_log[0].write && dram_log[0].addr == line_base(old_addr))
        else report_mismatch($sformatf("first DRAM request at %h is not the writeback",
                                       dram_log[0].addr));
    assert (dram_log[0].data == old_line)
        else report_mismatch($sformatf("writeback line %h, expected %h",
                                       dram_log[0].data, old_line));
    assert (!dram_log[1].write && dram_log[1].addr == line_base(new_addr))
        else report_mismatch($sformatf("second DRAM request at %h is not the fill",
                                       dram_log[1].addr));
    // Old line comes back from DRAM with the merged bytes
    issue(OP_READ, old_addr, '0, '0);
    wait_idle();
endtask

task automatic check_flush();
    logic [31:0] addr;
    addr = 32'h0000_3350;
    issue(OP_WRITE, addr, 32'hdead_beef, 4'b1111);
    wait_idle();
    dram_log.delete();
    issue(OP_FLUSH, addr, '0, '0);
    wait_idle();
    assert (dram_log.size() == 1 && dram_log[0].write)
        else report_mismatch("a dirty flush did not write back exactly once");
    assert (dram_log[0].addr == line_base(addr) &&
            dram_log[0].data[addr[3:2]] == ref_word(addr))
        else report_mismatch($sformatf("flush wrote %h at %h",
                                       dram_log[0].data, dram_log[0].addr));
    dram_log.delete();
    issue(OP_READ, addr, '0, '0);
    wait_idle();
    assert (dram_log.size() == 1 && !dram_log[0].write)
        else report_mismatch("a read after flush did not refill the line");
    dram_log.delete();
    issue(OP_FLUSH, 32'h0007_7760, '0, '0);
    wait_idle();
    assert (dram_log.size() == 0) else report_mismatch("a flush miss reached DRAM");
endtask

task automatic check_credit_burst();
    logic [31:0] addr;
    int          stalls;
    dram_extra = 8;
    stalls     = 0;
    repeat (40) begin
        addr = {24'h00a001 + 24'($urandom_range(0, 2)), 4'($urandom_range(0, 15)),
                2'($urandom_range(0, 3)), 2'b00};
        // A busy controller leaves the core without credits
        if (credits == 0) begin
            stalls++;
        end
        if ($urandom_range(0, 1) == 1) begin
            issue(OP_WRITE, addr, $urandom(), 4'($urandom_range(0, 15)));
        end else begin
            issue(OP_READ, addr, '0, '0);
        end
    end
    wait_idle();
    dram_extra = 0;
    assert (stalls > 0) else report_mismatch("the core never ran out of request credits");
endtask

`endif

// File: test/cache_bank_tb.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_bank_tb
    import cache_pkg::*;
;

    localparam int          WAIT_LIMIT  = 2000;
    localparam logic [31:0] PATTERN_KEY = 32'hc0de_0000;

    logic        clk;
    logic        reset;
    logic        core_req_valid;
    cache_op_t   core_req_op;
    logic [31:0] core_req_addr;
    logic [31:0] core_req_wdata;
    logic [3:0]  core_req_byte_en;
    logic        core_req_credit;
    logic        core_rsp_valid;
    logic [31:0] core_rsp_data;
    logic        dram_req_valid;
    logic        dram_req_write;
    logic [31:0] dram_req_addr;
    line_data_t  dram_req_data;
    logic        dram_req_credit;
    logic        dram_rsp_valid;
    line_data_t  dram_rsp_data;

    // Core side bookkeeping
    int          credits;
    int          cycle;
    int          req_cycle;
    int          rsp_cycle;
    logic [31:0] last_rsp;
    logic [31:0] exp_q [$];
    logic [31:0] ref_mem [logic [29:0]];

    // DRAM model state
    logic [31:0] dram_mem [logic [29:0]];
    dram_req_t   dram_log [$];
    int          pend_due [$];
    logic        pend_read [$];
    logic [31:0] pend_addr [$];
    int          last_due;
    int          outstanding;
    int          dram_extra;

    cache_bank dut_i (
        .clk              (clk),
        .reset            (reset),
        .core_req_valid   (core_req_valid),
        .core_req_op      (core_req_op),
        .core_req_addr    (core_req_addr),
        .core_req_wdata   (core_req_wdata),
        .core_req_byte_en (core_req_byte_en),
        .core_req_credit  (core_req_credit),
        .core_rsp_valid   (core_rsp_valid),
        .core_rsp_data    (core_rsp_data),
        .dram_req_valid   (dram_req_valid),
        .dram_req_write   (dram_req_write),
        .dram_req_addr    (dram_req_addr),
        .dram_req_data    (dram_req_data),
        .dram_req_credit  (dram_req_credit),
        .dram_rsp_valid   (dram_rsp_valid),
        .dram_rsp_data    (dram_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_timeout(input string msg);
        $display("Gave up waiting: %s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping on a timeout");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Initial memory contents, word address XOR a constant
    function automatic logic [31:0] pattern_word(input logic [29:0] key);
        return {2'b00, key} ^ PATTERN_KEY;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        if (ref_mem.exists(addr[31:2])) begin
            return ref_mem[addr[31:2]];
        end
        return pattern_word(addr[31:2]);
    endfunction

    function automatic logic [31:0] dram_word(input logic [31:0] addr);
        if (dram_mem.exists(addr[31:2])) begin
            return dram_mem[addr[31:2]];
        end
        return pattern_word(addr[31:2]);
    endfunction

    function automatic logic [31:0] line_base(input logic [31:0] addr);
        return addr & ~(32'(`CACHE_LINE_BYTES) - 32'd1);
    endfunction

    function automatic line_data_t dram_line(input logic [31:0] addr);
        line_data_t line;
        for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
            line[w] = dram_word(line_base(addr) + 32'(4 * w));
        end
        return line;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  byte_en);
        logic [31:0] result;
        for (int b = 0; b < 4; b++) begin
            result[b * 8 +: 8] = byte_en[b] ? new_word[b * 8 +: 8] : old_word[b * 8 +: 8];
        end
        return result;
    endfunction

    // Sends one request once a credit is held, and queues the expected response
    task automatic issue(input cache_op_t op, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [3:0] byte_en);
        int          waited;
        logic [31:0] expected;
        waited = 0;
        while (credits == 0) begin
            if (waited >= WAIT_LIMIT) begin
                report_timeout("the core never got a request credit back");
            end
            next_cycle();
            waited++;
        end
        expected = '0;
        if (op == OP_READ) begin
            expected = ref_word(addr);
        end else if (op == OP_WRITE) begin
            expected = merge_bytes(ref_word(addr), wdata, byte_en);
            ref_mem[addr[31:2]] = expected;
        end
        exp_q.push_back(expected);
        credits--;
        core_req_valid   = 1'b1;
        core_req_op      = op;
        core_req_addr    = addr;
        core_req_wdata   = wdata;
        core_req_byte_en = byte_en;
        next_cycle();
        core_req_valid   = 1'b0;
    endtask

    // Idle means all responses seen and the DRAM queue drained
    task automatic wait_idle();
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        while (quiet < 4) begin
            if (waited >= WAIT_LIMIT) begin
                report_timeout("the bank did not finish its outstanding requests");
            end
            next_cycle();
            waited++;
            if (exp_q.size() == 0 && outstanding == 0 && !dram_req_valid) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    // Samples at the falling edge, DRAM replies go out just after the rising edge
    always @(negedge clk) begin : link_monitor
        dram_req_t  seen;
        logic       credit_now;
        logic       rsp_now;
        line_data_t rsp_line;
        int         due;
        credit_now = 1'b0;
        rsp_now    = 1'b0;
        rsp_line   = '0;
        if (!reset) begin
            cycle++;
            if (core_req_valid) begin
                req_cycle = cycle;
            end
            if (core_req_credit) begin
                credits++;
                assert (credits <= `CORE_REQQ_DEPTH)
                    else report_mismatch($sformatf("core holds %0d credits", credits));
            end
            if (core_rsp_valid) begin
                rsp_cycle = cycle;
                last_rsp  = core_rsp_data;
                assert (exp_q.size() > 0) else report_mismatch("response with no request");
                assert (core_rsp_data === exp_q[0])
                    else report_mismatch($sformatf("response %h, expected %h",
                                                   core_rsp_data, exp_q[0]));
                void'(exp_q.pop_front());
            end
            if (pend_due.size() > 0 && pend_due[0] == cycle) begin
                credit_now = 1'b1;
                outstanding--;
                if (pend_read[0]) begin
                    rsp_now  = 1'b1;
                    rsp_line = dram_line(pend_addr[0]);
                end
                void'(pend_due.pop_front());
                void'(pend_read.pop_front());
                void'(pend_addr.pop_front());
            end
            if (dram_req_valid) begin
                seen.write = dram_req_write;
                seen.addr  = dram_req_addr;
                seen.data  = dram_req_data;
                dram_log.push_back(seen);
                outstanding++;
                assert (outstanding <= `DRAM_REQ_CREDITS)
                    else report_mismatch($sformatf("%0d DRAM requests outstanding", outstanding));
                if (seen.write) begin
                    for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
                        dram_mem[seen.addr[31:2] + 30'(w)] = seen.data[w];
                    end
                end
                // Replies stay in order, one per cycle at most
                due = cycle + int'($urandom_range(1, 8)) + dram_extra;
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                pend_due.push_back(due);
                pend_read.push_back(!seen.write);
                pend_addr.push_back(seen.addr);
            end
        end
        @(posedge clk);
        #1;
        dram_req_credit = credit_now;
        dram_rsp_valid  = rsp_now;
        dram_rsp_data   = rsp_line;
    end

    `include "cache_bank_tests.svh"

    initial begin
        void'($urandom(32'h39b5_c47c));
        credits          = `CORE_REQQ_DEPTH;
        cycle            = 0;
        req_cycle        = 0;
        rsp_cycle        = 0;
        last_rsp         = '0;
        last_due         = 0;
        outstanding      = 0;
        dram_extra       = 0;
        reset            = 1'b1;
        core_req_valid   = 1'b0;
        core_req_op      = OP_READ;
        core_req_addr    = '0;
        core_req_wdata   = '0;
        core_req_byte_en = '0;
        dram_req_credit  = 1'b0;
        dram_rsp_valid   = 1'b0;
        dram_rsp_data    = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        check_reset_quiet();
        check_read_miss_hit();
        check_byte_writes();
        check_eviction();
        check_flush();
        check_credit_burst();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
